// File: common/noc_flit_pkg.sv
// Flit types carried on every data path of the router slice.
// Import into a module body, or use scoped names in port lists.

`default_nettype none

package noc_flit_pkg;

  // Width of the data word in one flit
  localparam int FlitDataW = 16;

  // One data word of a flit
  typedef logic [FlitDataW-1:0] flit_payload_t;

  // Flit as it travels through FIFOs, output stage and link
  // The last flag marks the tail of a packet, the arbiter releases its lock on it
  typedef struct packed {
    logic          last;
    flit_payload_t payload;
  } flit_t;

endpackage

`default_nettype wire

// File: common/noc_flow_pkg.sv
// Flow control constants and types of the router slice.
// Covers port count, credit budgets, FIFO depth and the arbiter states.

`default_nettype none

package noc_flow_pkg;

  // Number of upstream input ports
  localparam int NumInPorts = 2;

  // Input FIFO depth, also the credits each upstream sender starts with
  localparam int InFifoDepth = 2;

  // Free downstream slots after reset
  localparam int OutCredits = 4;

  // Counter must be able to hold OutCredits itself
  localparam int CreditCntW = $clog2(OutCredits + 1);

  typedef logic [CreditCntW-1:0] credit_cnt_t;

  // One bit per input port, for valid, pop and credit vectors
  typedef logic [NumInPorts-1:0] port_vec_t;

  // Wormhole arbiter FSM
  typedef enum logic {
    ARB_IDLE,
    ARB_LOCKED
  } arb_state_e;

endpackage

`default_nettype wire

// File: design/input_fifo/flit_input_fifo.sv
// Shallow input buffer for one router port, built as a chain of registers.
// Takes a write while full as long as the head is popped in the same cycle.
// Depth may be 1, 2 or 3.

`timescale 1ns/1ns
`default_nettype none

module flit_input_fifo #(
  parameter int Depth = 2
) (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire                      valid_i,
  input  wire noc_flit_pkg::flit_t data_i,
  output logic                     valid_o,
  input  wire                      ready_i,
  output noc_flit_pkg::flit_t      data_o
);
  import noc_flit_pkg::*;

  // Register 0 is the entry, higher indices hold older flits
  // Full flags are a thermometer, so register k full means all below it are full
  flit_t            data_q [Depth];
  logic [Depth-1:0] full_q;
  logic [Depth-1:0] full_d;
  logic             accept;
  logic             push;
  logic             pop;

  // Only the register chain variants exist
  if (Depth < 1 || Depth > 3) begin : gen_depth_check
    $error("flit_input_fifo supports depths 1 to 3 only");
  end

  // Room left, or the oldest flit leaves this cycle
  assign accept = ~full_q[Depth-1] | ready_i;
  assign push   = valid_i & accept;
  assign pop    = valid_o & ready_i;

  // Any register full means the entry register is full
  assign valid_o = full_q[0];

  // Occupancy moves by one step up or down, stays on push with pop
  always_comb begin
    full_d = full_q;
    if (push && !pop) begin
      full_d[0] = 1'b1;
      for (int k = 1; k < Depth; k++) begin
        full_d[k] = full_q[k-1];
      end
    end else if (pop && !push) begin
      full_d[Depth-1] = 1'b0;
      for (int k = 0; k < Depth - 1; k++) begin
        full_d[k] = full_q[k+1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= '0;
    end else begin
      full_q <= full_d;
    end
  end

  // New flit always lands in the entry register
  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q[0] <= data_i;
    end
  end

  // Shift a register on only when it must be full after this write
  // On push with pop the popped slot is simply overwritten from below
  always_ff @(posedge clk_i) begin
    for (int k = 1; k < Depth; k++) begin
      if (push && full_d[k]) begin
        data_q[k] <= data_q[k-1];
      end
    end
  end

  // Head is the deepest full register, i.e. the oldest flit
  always_comb begin
    data_o = data_q[0];
    for (int k = 1; k < Depth; k++) begin
      if (full_q[k]) begin
        data_o = data_q[k];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/wormhole_arbiter.sv
// Wormhole arbiter for the input FIFOs of the slice.
// Grants round-robin, then stays on one port until its last flit is popped.
// Pops only while a downstream credit is available.

`timescale 1ns/1ns
`default_nettype none

module wormhole_arbiter (
  input  wire                          clk_i,
  input  wire                          reset_i,
  input  wire noc_flow_pkg::port_vec_t fifo_valid_i,
  input  wire noc_flow_pkg::port_vec_t head_last_i,
  input  wire                          credit_avail_i,
  output noc_flow_pkg::port_vec_t      pop_o
);
  import noc_flow_pkg::*;

  arb_state_e state_q;
  arb_state_e state_d;
  // One-hot record of the last port served and of the locked port in ARB_LOCKED
  port_vec_t  owner_q;
  port_vec_t  grant;
  logic       tail_pop;

  always_comb begin
    int   last_idx;
    int   idx;
    logic found;
    last_idx = 0;
    idx      = 0;
    found    = 1'b0;
    grant    = '0;
    for (int p = 0; p < NumInPorts; p++) begin
      if (owner_q[p]) begin
        last_idx = p;
      end
    end
    if (state_q == ARB_LOCKED) begin
      // Wait on the locked port even if its next flit is not there yet
      grant = owner_q & fifo_valid_i;
    end else begin
      // Search starts one past the port served last
      for (int off = 1; off <= NumInPorts; off++) begin
        idx = (last_idx + off) % NumInPorts;
        if (!found && fifo_valid_i[idx]) begin
          grant[idx] = 1'b1;
          found      = 1'b1;
        end
      end
    end
  end

  // No pop without a free slot downstream
  assign pop_o    = credit_avail_i ? grant : '0;
  assign tail_pop = |(pop_o & head_last_i);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // Lock only when a packet has more flits to follow
      ARB_IDLE:   if (|pop_o && !tail_pop) state_d = ARB_LOCKED;
      ARB_LOCKED: if (tail_pop) state_d = ARB_IDLE;
      default:    state_d = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ARB_IDLE;
      // Pretend the top port was served so port 0 goes first
      owner_q <= port_vec_t'(1) << (NumInPorts - 1);
    end else begin
      state_q <= state_d;
      if (|pop_o) begin
        owner_q <= pop_o;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/credit_counter.sv
// Downstream credit tracker for the output link.
// One credit spent per flit sent, one regained per returned credit strobe.

`timescale 1ns/1ns
`default_nettype none

module credit_counter (
  input  wire  clk_i,
  input  wire  reset_i,
  input  wire  send_i,
  input  wire  credit_i,
  output logic credit_avail_o
);
  import noc_flow_pkg::*;

  credit_cnt_t count_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // All downstream slots free
      count_q <= credit_cnt_t'(OutCredits);
    end else begin
      unique case ({send_i, credit_i})
        2'b10:   count_q <= count_q - credit_cnt_t'(1);
        2'b01:   count_q <= count_q + credit_cnt_t'(1);
        // Send and return together cancel out
        default: count_q <= count_q;
      endcase
    end
  end

  // Arbiter may pop while a slot is left
  assign credit_avail_o = (count_q != '0);

endmodule

`default_nettype wire

// File: design/flit_output_stage.sv
// Output register of the slice.
// Picks the popped head flit onto the link one cycle later and
// hands a credit back to the port the flit came from.

`timescale 1ns/1ns
`default_nettype none

module flit_output_stage (
  input  wire                                                     clk_i,
  input  wire                                                     reset_i,
  input  wire noc_flow_pkg::port_vec_t                            pop_i,
  input  wire noc_flit_pkg::flit_t [noc_flow_pkg::NumInPorts-1:0] head_i,
  output noc_flit_pkg::flit_t                                     flit_o,
  output logic                                                    flit_valid_o,
  output noc_flow_pkg::port_vec_t                                 credit_o
);
  import noc_flit_pkg::*;
  import noc_flow_pkg::*;

  flit_t     sel_flit;
  flit_t     flit_q;
  logic      valid_q;
  port_vec_t credit_q;

  // Pop is one-hot, so at most one head passes
  always_comb begin
    sel_flit = '0;
    for (int p = 0; p < NumInPorts; p++) begin
      if (pop_i[p]) begin
        sel_flit = head_i[p];
      end
    end
  end

  // Strobes for link valid and upstream credits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= 1'b0;
      credit_q <= '0;
    end else begin
      valid_q  <= |pop_i;
      credit_q <= pop_i;
    end
  end

  // Link payload, only meaningful with the valid strobe
  always_ff @(posedge clk_i) begin
    if (|pop_i) begin
      flit_q <= sel_flit;
    end
  end

  assign flit_o       = flit_q;
  assign flit_valid_o = valid_q;
  assign credit_o     = credit_q;

endmodule

`default_nettype wire

// File: design/flit_router_slice.sv
// Top of the two-input, one-output router slice with credit flow control.
// Upstream strobes flits per port and gets credits back on credit_o,
// downstream receives flit strobes and returns credits on credit_i.

`timescale 1ns/1ns
`default_nettype none

module flit_router_slice (
  input  wire                                                     clk_i,
  input  wire                                                     reset_i,
  input  wire noc_flow_pkg::port_vec_t                            flit_valid_i,
  input  wire noc_flit_pkg::flit_t [noc_flow_pkg::NumInPorts-1:0] flit_i,
  output noc_flow_pkg::port_vec_t                                 credit_o,
  output noc_flit_pkg::flit_t                                     flit_o,
  output logic                                                    flit_valid_o,
  input  wire                                                     credit_i
);
  import noc_flit_pkg::*;
  import noc_flow_pkg::*;

  port_vec_t              fifo_valid;
  port_vec_t              head_last;
  port_vec_t              pop;
  flit_t [NumInPorts-1:0] head;
  logic                   credit_avail;
  logic                   send;

  // One input FIFO per port, popped by its arbiter bit
  for (genvar p = 0; p < NumInPorts; p++) begin : gen_in_port
    flit_input_fifo #(
      .Depth (InFifoDepth)
    ) i_input_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .valid_i (flit_valid_i[p]),
      .data_i  (flit_i[p]),
      .valid_o (fifo_valid[p]),
      .ready_i (pop[p]),
      .data_o  (head[p])
    );

    assign head_last[p] = head[p].last;
  end

  wormhole_arbiter i_arbiter (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fifo_valid_i   (fifo_valid),
    .head_last_i    (head_last),
    .credit_avail_i (credit_avail),
    .pop_o          (pop)
  );

  // Any pop spends one downstream credit
  assign send = |pop;

  credit_counter i_credit_counter (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .send_i         (send),
    .credit_i       (credit_i),
    .credit_avail_o (credit_avail)
  );

  flit_output_stage i_output_stage (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .pop_i        (pop),
    .head_i       (head),
    .flit_o       (flit_o),
    .flit_valid_o (flit_valid_o),
    .credit_o     (credit_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_flit_router_slice.sv
// Testbench for the two-input router slice.
// Replays per-cycle stimulus from bench/slice_testdata.txt, tracks both credit
// loops and checks the output flit order and packet integrity.

`timescale 1ns/1ns
`default_nettype none

module tb_flit_router_slice;
  import noc_flit_pkg::*;
  import noc_flow_pkg::*;

  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 16;
  localparam int AddrW       = 8;
  localparam int MemWords    = 1 << AddrW;
  // Cycles allowed per remaining output flit
  localparam int DrainLimit  = 40;

  logic                   clk_i;
  logic                   reset_i;
  port_vec_t              flit_valid_i;
  flit_t [NumInPorts-1:0] flit_i;
  port_vec_t              credit_o;
  flit_t                  flit_o;
  logic                   flit_valid_o;
  logic                   credit_i;

  // Row count, flit count, rows of five words, then expected flits
  logic [19:0] tdata [MemWords];

  int         num_rows;
  int         num_exp;
  int         exp_base;
  int         out_count;
  int         returned;
  int         up_credits [NumInPorts];
  // Port and packet number of the packet still open on the link
  logic       in_packet;
  logic [7:0] packet_id;

  flit_router_slice i_flit_router_slice (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flit_valid_i (flit_valid_i),
    .flit_i       (flit_i),
    .credit_o     (credit_o),
    .flit_o       (flit_o),
    .flit_valid_o (flit_valid_o),
    .credit_i     (credit_i)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  function automatic logic [19:0] word_at(input int addr);
    return tdata[AddrW'(addr)];
  endfunction

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
  endtask

  // Link and credit strobes must be quiet
  task automatic check_idle_outputs();
    assert (!flit_valid_o) else begin
      show_mismatch("flit_valid_o", 32'(flit_valid_o), 0);
      $display("Verification failed");
      $fatal(1);
    end
    assert (credit_o == '0) else begin
      show_mismatch("credit_o", 32'(credit_o), 0);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // Sampled on the falling edge, before the next row is driven
  task automatic check_outputs();
    logic [19:0] word;
    flit_t       exp_flit;
    for (int p = 0; p < NumInPorts; p++) begin
      if (credit_o[p]) begin
        up_credits[p]++;
      end
      assert (up_credits[p] <= InFifoDepth) else begin
        $display("Port %0d got back more credits than it spent", p);
        $display("Verification failed");
        $fatal(1);
      end
    end
    if (flit_valid_o) begin
      out_count++;
      assert (out_count <= OutCredits + returned) else begin
        $display("A flit left without a free downstream slot at %0t ns", $time);
        $display("Verification failed");
        $fatal(1);
      end
      assert (out_count <= num_exp) else begin
        $display("More output flits than the data file expects");
        $display("Verification failed");
        $fatal(1);
      end
      word     = word_at(exp_base + out_count - 1);
      exp_flit = word[16:0];
      assert (flit_o == exp_flit) else begin
        show_mismatch("flit_o", 32'(flit_o), 32'(exp_flit));
        $display("Verification failed");
        $fatal(1);
      end
      // Payload bits 15:8 carry the port and packet number
      if (in_packet) begin
        assert (flit_o.payload[15:8] == packet_id) else begin
          show_mismatch("flit_o packet id", 32'(flit_o.payload[15:8]), 32'(packet_id));
          $display("Verification failed");
          $fatal(1);
        end
      end
      packet_id = flit_o.payload[15:8];
      in_packet = !flit_o.last;
    end
  endtask

  task automatic drive_row(input int row);
    int          base;
    logic [19:0] word;
    base = 2 + row * 5;
    for (int p = 0; p < NumInPorts; p++) begin
      word            = word_at(base + 2 * p);
      flit_valid_i[p] = word[0];
      word            = word_at(base + 2 * p + 1);
      flit_i[p]       = word[16:0];
      if (flit_valid_i[p]) begin
        assert (up_credits[p] > 0) else begin
          $display("Row %0d strobes port %0d while it holds no credit", row, p);
          $display("Verification failed");
          $fatal(1);
        end
        up_credits[p]--;
      end
    end
    word     = word_at(base + 4);
    credit_i = word[0];
    if (credit_i) begin
      returned++;
    end
  endtask

  initial begin
    int waited;
    int target;
    flit_valid_i = '0;
    flit_i       = '0;
    credit_i     = 1'b0;
    reset_i      = 1'b1;
    out_count    = 0;
    returned     = 0;
    in_packet    = 1'b0;
    packet_id    = '0;
    for (int p = 0; p < NumInPorts; p++) begin
      up_credits[p] = InFifoDepth;
    end
    $readmemh("bench/slice_testdata.txt", tdata);
    num_rows = int'(tdata[0]);
    num_exp  = int'(tdata[1]);
    exp_base = 2 + num_rows * 5;
    assert (num_exp > 0 && exp_base + num_exp <= MemWords) else begin
      $display("Data file is missing or its counts do not fit");
      $display("Verification failed");
      $fatal(1);
    end

    repeat (ResetCycles) begin
      @(negedge clk_i);
      check_idle_outputs();
    end
    reset_i = 1'b0;
    @(negedge clk_i);
    check_idle_outputs();

    for (int r = 0; r < num_rows; r++) begin
      @(negedge clk_i);
      check_outputs();
      drive_row(r);
    end

    // Inputs go quiet while the remaining flits drain
    while (out_count < num_exp) begin
      target = out_count + 1;
      waited = 0;
      while (out_count < target) begin
        @(negedge clk_i);
        check_outputs();
        flit_valid_i = '0;
        credit_i     = 1'b0;
        waited++;
        assert (waited < DrainLimit) else begin
          $display("Timed out waiting for output flit %0d", target);
          $display("Verification failed");
          $fatal(1);
        end
      end
    end

    // Catch stray flits after the list is done
    repeat (4) begin
      @(negedge clk_i);
      check_outputs();
      flit_valid_i = '0;
      credit_i     = 1'b0;
    end
    assert (!in_packet) else begin
      $display("Last packet on the link never saw its last flit");
      $display("Verification failed");
      $fatal(1);
    end
    for (int p = 0; p < NumInPorts; p++) begin
      assert (up_credits[p] == InFifoDepth) else begin
        show_mismatch("upstream credits", 32'(up_credits[p]), 32'(InFifoDepth));
        $display("Verification failed");
        $fatal(1);
      end
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/slice_testdata.txt
// Word 0 is the row count, word 1 the expected flit count (hex)
// Rows: valid0 flit0 valid1 flit1 credit_i, flit = {last, port, packet, index}
11
9
1 00100 1 01100 0
1 10101 1 11101 0
1 00200 0 00000 0
1 10201 0 00000 0
0 00000 1 01200 0
0 00000 1 11201 0
0 00000 0 00000 0
0 00000 0 00000 0
0 00000 0 00000 1
0 00000 0 00000 1
0 00000 0 00000 1
0 00000 0 00000 1
1 10300 0 00000 1
0 00000 0 00000 1
0 00000 0 00000 1
0 00000 0 00000 1
0 00000 0 00000 1
// Expected output flits in link order
00100 10101 01100
11101 00200 10201
01200 11201 10300

// File: vlog.f
common/noc_flit_pkg.sv
common/noc_flow_pkg.sv
design/input_fifo/flit_input_fifo.sv
design/wormhole_arbiter.sv
design/credit_counter.sv
design/flit_output_stage.sv
design/flit_router_slice.sv
bench/tb_flit_router_slice.sv

// File: run_sim.sh
#!/bin/sh
# Build and run from the project root, the exit status is the test result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_flit_router_slice -Mdir obj_dir -f vlog.f &&
./obj_dir/Vtb_flit_router_slice ||
exit 1
